/* tb.f */
+incdir+rtl
rtl/link_types_pkg.sv
rtl/link_regs_pkg.sv
rtl/bit_tick_gen.sv
rtl/link_config_regs.sv
rtl/link_partner.sv
rtl/link_pair_top.sv
tb/link_pair_tb.sv

/* tb/link_pair_tb.sv */
`default_nettype none

`include "link_cfg.svh"

module link_pair_tb;

    import link_regs_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int RAND_SEED    = 24327;
    localparam int NUM_ROWS     = 16;
    // Longest frame is sync, data_m, turn, data_s and a full gap
    localparam int MAX_FRAME_SLOTS = 4 + (2 ** `LINK_GAP_WIDTH) - 1;
    localparam int FRAME_WAIT      = 3 * MAX_FRAME_SLOTS * `LINK_TICK_DIV;
    // Register traffic and lock settling per row
    localparam int ROW_MARGIN    = 32;
    localparam int WATCHDOG_TIME = (NUM_ROWS * (FRAME_WAIT + ROW_MARGIN) + 64) * CLK_PERIOD;

    logic       clk_8mhz = 1'b0;
    logic       reset;
    logic       pll_locked;
    logic       state_a_in;
    logic       state_b_in;
    logic       cfg_write;
    reg_addr_t  cfg_addr;
    logic [7:0] cfg_wdata;
    wire        partner_a_state;
    wire        partner_b_state;
    wire        state_a_echo;
    wire        state_b_echo;
    wire  [7:0] cfg_rdata;

    // Stimulus table with one entry per row
    string       row_name   [NUM_ROWS];
    logic        row_sa     [NUM_ROWS];
    logic        row_sb     [NUM_ROWS];
    logic        row_am     [NUM_ROWS];
    logic  [7:0] row_gap    [NUM_ROWS];
    logic        row_en     [NUM_ROWS];
    logic        row_lock   [NUM_ROWS];
    logic        row_rand   [NUM_ROWS];
    logic        row_exp_pa [NUM_ROWS];
    logic        row_exp_pb [NUM_ROWS];
    int          n_rows;
    int          errors;
    int          checks;
    // Echo model follows the inputs only while the link runs
    logic        exp_echo_a;
    logic        exp_echo_b;

    link_pair_top link_pair_top_inst (
        .clk_8mhz        (clk_8mhz),
        .reset           (reset),
        .pll_locked      (pll_locked),
        .state_a_in      (state_a_in),
        .state_b_in      (state_b_in),
        .partner_a_state (partner_a_state),
        .partner_b_state (partner_b_state),
        .state_a_echo    (state_a_echo),
        .state_b_echo    (state_b_echo),
        .cfg_write       (cfg_write),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata)
    );

    always #(CLK_PERIOD / 2) clk_8mhz = ~clk_8mhz;

    //////////////////////////////////////////////////
    // Table building
    //////////////////////////////////////////////////

    task automatic add_row(input string name, input logic sa, input logic sb,
                           input logic am, input logic [7:0] gap, input logic en,
                           input logic lock, input logic rnd, input logic ea,
                           input logic eb);
        row_name[n_rows]   = name;
        row_sa[n_rows]     = sa;
        row_sb[n_rows]     = sb;
        row_am[n_rows]     = am;
        row_gap[n_rows]    = gap;
        row_en[n_rows]     = en;
        row_lock[n_rows]   = lock;
        row_rand[n_rows]   = rnd;
        row_exp_pa[n_rows] = ea;
        row_exp_pb[n_rows] = eb;
        n_rows++;
    endtask

    task automatic fill_random_rows;
        for (int i = 0; i < n_rows; i++) begin
            if (row_rand[i]) begin
                row_sa[i]     = 1'($urandom % 2);
                row_sb[i]     = 1'($urandom % 2);
                // Running link gives each side the other's bit
                row_exp_pa[i] = row_sb[i];
                row_exp_pb[i] = row_sa[i];
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Register port and checks
    //////////////////////////////////////////////////

    task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
        @(posedge clk_8mhz);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_8mhz);
        cfg_write <= 1'b0;
    endtask

    // Read data is combinational and taken mid-cycle
    task automatic read_reg(input reg_addr_t addr, output logic [7:0] data);
        @(posedge clk_8mhz);
        cfg_addr <= addr;
        @(negedge clk_8mhz);
        data = cfg_rdata;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %0h, actual %0h",
                     name, what, expected, actual);
        end
    endtask

    task automatic apply_row(input int i);
        logic [7:0] rdata;
        logic [7:0] ctrl_val;
        logic [7:0] gap_exp;
        ctrl_val = {6'd0, row_am[i], row_en[i]};
        // Zero gap reads back as one slot
        gap_exp  = (row_gap[i] == 8'd0) ? 8'd1 : row_gap[i];
        write_reg(reg_ctrl, ctrl_val);
        read_reg(reg_ctrl, rdata);
        check_value(row_name[i], "ctrl", ctrl_val, rdata);
        // Control write clears the error count
        read_reg(reg_status, rdata);
        check_value(row_name[i], "status", 8'd0, rdata);
        write_reg(reg_gap, row_gap[i]);
        read_reg(reg_gap, rdata);
        check_value(row_name[i], "gap", gap_exp, rdata);
        // Lock change settles before the inputs move
        @(posedge clk_8mhz);
        pll_locked <= row_lock[i];
        repeat (2) @(posedge clk_8mhz);
        state_a_in <= row_sa[i];
        state_b_in <= row_sb[i];
        repeat (FRAME_WAIT) @(posedge clk_8mhz);
        @(negedge clk_8mhz);
        if (row_en[i] && row_lock[i]) begin
            exp_echo_a = row_sa[i];
            exp_echo_b = row_sb[i];
        end
        check_value(row_name[i], "partner_a_state", row_exp_pa[i], partner_a_state);
        check_value(row_name[i], "partner_b_state", row_exp_pb[i], partner_b_state);
        check_value(row_name[i], "state_a_echo", exp_echo_a, state_a_echo);
        check_value(row_name[i], "state_b_echo", exp_echo_b, state_b_echo);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [7:0] rdata;
        void'($urandom(RAND_SEED));
        reset      = 1'b1;
        pll_locked = 1'b0;
        state_a_in = 1'b0;
        state_b_in = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = reg_ctrl;
        cfg_wdata  = 8'd0;
        n_rows     = 0;
        errors     = 0;
        checks     = 0;
        exp_echo_a = 1'b0;
        exp_echo_b = 1'b0;
        // Name, a, b, A master, gap, enable, lock, random, expected A, expected B
        add_row("ab_00", 0, 0, 1, 8'd1, 1, 1, 0, 0, 0);
        add_row("ab_01", 0, 1, 1, 8'd1, 1, 1, 0, 1, 0);
        add_row("ab_10", 1, 0, 1, 8'd1, 1, 1, 0, 0, 1);
        add_row("ab_11", 1, 1, 1, 8'd1, 1, 1, 0, 1, 1);
        add_row("b_master_01", 0, 1, 0, 8'd1, 1, 1, 0, 1, 0);
        add_row("b_master_10", 1, 0, 0, 8'd7, 1, 1, 0, 0, 1);
        add_row("gap_7", 1, 1, 1, 8'd7, 1, 1, 0, 1, 1);
        add_row("gap_15", 0, 1, 1, 8'd15, 1, 1, 0, 1, 0);
        add_row("gap_0_as_1", 1, 0, 0, 8'd0, 1, 1, 0, 0, 1);
        // Outputs hold the previous row's values
        add_row("disabled_hold", 0, 1, 1, 8'd1, 0, 1, 0, 0, 1);
        add_row("reenable", 0, 1, 1, 8'd1, 1, 1, 0, 1, 0);
        add_row("unlocked_hold", 1, 0, 1, 8'd1, 1, 0, 0, 1, 0);
        add_row("relock", 1, 0, 1, 8'd1, 1, 1, 0, 0, 1);
        // State bits and expected values filled below
        add_row("random_0", 0, 0, 1, 8'd3, 1, 1, 1, 0, 0);
        add_row("random_1", 0, 0, 0, 8'd2, 1, 1, 1, 0, 0);
        add_row("random_2", 0, 0, 1, 8'd5, 1, 1, 1, 0, 0);
        fill_random_rows();

        repeat (RESET_CYCLES) @(posedge clk_8mhz);
        reset <= 1'b0;
        @(negedge clk_8mhz);
        check_value("reset", "partner_a_state", 8'd0, partner_a_state);
        check_value("reset", "partner_b_state", 8'd0, partner_b_state);
        check_value("reset", "state_a_echo", 8'd0, state_a_echo);
        check_value("reset", "state_b_echo", 8'd0, state_b_echo);
        // Disabled with A as master
        read_reg(reg_ctrl, rdata);
        check_value("reset", "ctrl", 8'h02, rdata);
        read_reg(reg_gap, rdata);
        check_value("reset", "gap", 8'(`LINK_GAP_DEFAULT), rdata);
        @(posedge clk_8mhz);
        pll_locked <= 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the stimulus table did not finish within %0d time units",
                 WATCHDOG_TIME);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/link_pair_top.sv */
`default_nettype none

`include "link_cfg.svh"

module link_pair_top (
    input  wire                       clk_8mhz,
    input  wire                       reset,
    input  wire                       pll_locked,
    input  wire                       state_a_in,
    input  wire                       state_b_in,
    output logic                      partner_a_state,
    output logic                      partner_b_state,
    output logic                      state_a_echo,
    output logic                      state_b_echo,
    input  wire                       cfg_write,
    input  link_regs_pkg::reg_addr_t  cfg_addr,
    input  wire  [7:0]                cfg_wdata,
    output logic [7:0]                cfg_rdata
);

    import link_types_pkg::*;

    logic                       slot_tick;
    logic                       link_enable;
    role_t                      role_a;
    role_t                      role_b;
    logic [`LINK_GAP_WIDTH-1:0] gap_slots;
    logic                       sync_error_a;
    logic                       sync_error_b;
    logic                       line_out_a;
    logic                       line_oe_a;
    logic                       line_out_b;
    logic                       line_oe_b;
    logic                       shared_line;

    //////////////////////////////////////////////////
    // Slot timing and configuration
    //////////////////////////////////////////////////

    bit_tick_gen bit_tick_gen_inst (
        .clk_8mhz   (clk_8mhz),
        .reset      (reset),
        .pll_locked (pll_locked),
        .slot_tick  (slot_tick)
    );

    link_config_regs link_config_regs_inst (
        .clk_8mhz     (clk_8mhz),
        .reset        (reset),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .sync_error_a (sync_error_a),
        .sync_error_b (sync_error_b),
        .link_enable  (link_enable),
        .role_a       (role_a),
        .role_b       (role_b),
        .gap_slots    (gap_slots)
    );

    //////////////////////////////////////////////////
    // Partners on the shared line
    //////////////////////////////////////////////////

    link_partner partner_a (
        .clk_8mhz      (clk_8mhz),
        .reset         (reset),
        .slot_tick     (slot_tick),
        .link_enable   (link_enable),
        .role          (role_a),
        .gap_slots     (gap_slots),
        .state_in      (state_a_in),
        .line_in       (shared_line),
        .line_out      (line_out_a),
        .line_oe       (line_oe_a),
        .partner_state (partner_a_state),
        .state_echo    (state_a_echo),
        .sync_error    (sync_error_a)
    );

    link_partner partner_b (
        .clk_8mhz      (clk_8mhz),
        .reset         (reset),
        .slot_tick     (slot_tick),
        .link_enable   (link_enable),
        .role          (role_b),
        .gap_slots     (gap_slots),
        .state_in      (state_b_in),
        .line_in       (shared_line),
        .line_out      (line_out_b),
        .line_oe       (line_oe_b),
        .partner_state (partner_b_state),
        .state_echo    (state_b_echo),
        .sync_error    (sync_error_b)
    );

    // Pulled-up wire, A first when enabled, then B
    assign shared_line = line_oe_a ? line_out_a :
                         line_oe_b ? line_out_b : 1'b1;

    // Only one side may own the line in any cycle
    assert property (@(posedge clk_8mhz) disable iff (reset)
        !(line_oe_a && line_oe_b))
        else $error("both partners drive the shared line");

endmodule

`default_nettype wire

/* rtl/link_partner.sv */
`default_nettype none

`include "link_cfg.svh"

module link_partner (
    input  wire                         clk_8mhz,
    input  wire                         reset,
    input  wire                         slot_tick,
    input  wire                         link_enable,
    input  link_types_pkg::role_t       role,
    input  wire  [`LINK_GAP_WIDTH-1:0]  gap_slots,
    input  wire                         state_in,
    input  wire                         line_in,
    output logic                        line_out,
    output logic                        line_oe,
    output logic                        partner_state,
    output logic                        state_echo,
    output logic                        sync_error
);

    import link_types_pkg::*;

    localparam int GAP_W = `LINK_GAP_WIDTH;

    // Slot in progress, ended by the next tick
    slot_state_t      state;
    slot_state_t      state_next;
    slot_state_t      start_state;
    logic [GAP_W-1:0] gap_cnt;
    // Master has driven its first sync since restart
    logic             armed;
    // Line level in the slot before the one just ended
    logic             line_prev;
    logic             my_state;
    role_t            role_q;
    logic             is_master;
    logic             restart;
    logic             sync_seen;
    logic             sync_miss;
    logic             gap_done;
    logic             oe_next;
    logic             out_next;

    assign is_master   = (role == role_master);
    assign start_state = is_master ? slot_sync : slot_hunt;
    // Role swap restarts the frame like a disable
    assign restart     = !link_enable || (role != role_q);
    // Sync is a low slot right after a high one
    assign sync_seen   = !line_in && line_prev;
    assign sync_miss   = !is_master && (state == slot_sync) && !sync_seen;
    assign gap_done    = (gap_cnt >= gap_slots);
    assign state_echo  = my_state;

    //////////////////////////////////////////////////
    // Frame sequencer, next slot
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            slot_hunt:   state_next = sync_seen ? slot_data_m : slot_hunt;
            slot_sync: begin
                if (is_master) begin
                    // First tick after restart opens the sync slot
                    state_next = armed ? slot_data_m : slot_sync;
                end else begin
                    state_next = sync_seen ? slot_data_m : slot_hunt;
                end
            end
            slot_data_m: state_next = slot_turn;
            slot_turn:   state_next = slot_data_s;
            slot_data_s: state_next = slot_gap;
            slot_gap:    state_next = gap_done ? slot_sync : slot_gap;
            default:     state_next = start_state;
        endcase
    end

    // Line driver setting for the slot about to start
    always_comb begin
        oe_next = is_master ? (state_next == slot_sync || state_next == slot_data_m)
                            : (state_next == slot_data_s);
        case (state_next)
            slot_sync:   out_next = 1'b0;
            slot_data_m: out_next = state_in;
            slot_data_s: out_next = my_state;
            default:     out_next = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // Sequencer and line driver registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_8mhz) begin
        if (reset || restart) begin
            state      <= start_state;
            gap_cnt    <= '0;
            armed      <= 1'b0;
            line_prev  <= 1'b1;
            line_oe    <= 1'b0;
            line_out   <= 1'b1;
            sync_error <= 1'b0;
        end else begin
            // One-cycle flag on a missed sync
            sync_error <= slot_tick && sync_miss;
            if (slot_tick) begin
                state     <= state_next;
                armed     <= 1'b1;
                line_prev <= line_in;
                line_oe   <= oe_next;
                line_out  <= out_next;
                if (state_next == slot_gap) begin
                    gap_cnt <= (state == slot_gap) ? gap_cnt + GAP_W'(1) : GAP_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_8mhz) begin
        role_q <= role;
    end

    //////////////////////////////////////////////////
    // Local capture and partner sampling
    //////////////////////////////////////////////////

    // Held across disable and unlock
    always_ff @(posedge clk_8mhz) begin
        if (reset) begin
            my_state      <= 1'b0;
            partner_state <= 1'b0;
        end else if (slot_tick && !restart) begin
            // Leaving the sync slot
            if (state_next == slot_data_m) begin
                my_state <= state_in;
            end
            // Sample the slot the other side owns
            if (is_master ? (state == slot_data_s) : (state == slot_data_m)) begin
                partner_state <= line_in;
            end
        end
    end

    // Drive only in the slots owned by this role
    assert property (@(posedge clk_8mhz) disable iff (reset)
        line_oe |-> ((role_q == role_master) ?
                     (state == slot_sync || state == slot_data_m) :
                     (state == slot_data_s)))
        else $error("line enabled outside own slot, state %s", state.name());

    // Resolved line reads back what this side drives, else the other side drove too
    assert property (@(posedge clk_8mhz) disable iff (reset)
        line_oe |-> (line_in == line_out))
        else $error("line contention seen in state %s", state.name());

endmodule

`default_nettype wire

/* rtl/link_config_regs.sv */
`default_nettype none

`include "link_cfg.svh"

module link_config_regs (
    input  wire                          clk_8mhz,
    input  wire                          reset,
    input  wire                          cfg_write,
    input  link_regs_pkg::reg_addr_t     cfg_addr,
    input  wire  [7:0]                   cfg_wdata,
    output logic [7:0]                   cfg_rdata,
    input  wire                          sync_error_a,
    input  wire                          sync_error_b,
    output logic                         link_enable,
    output link_types_pkg::role_t        role_a,
    output link_types_pkg::role_t        role_b,
    output logic [`LINK_GAP_WIDTH-1:0]   gap_slots
);

    import link_types_pkg::*;
    import link_regs_pkg::*;

    localparam int GAP_W = `LINK_GAP_WIDTH;
    localparam int ERR_W = `LINK_ERR_WIDTH;
    localparam logic [ERR_W-1:0] ERR_MAX = {ERR_W{1'b1}};

    logic             a_master_q;
    logic [ERR_W-1:0] err_cnt;
    logic             ctrl_wr;

    assign ctrl_wr = cfg_write && (cfg_addr == reg_ctrl);

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    always_ff @(posedge clk_8mhz) begin
        if (reset) begin
            link_enable <= 1'b0;
            a_master_q  <= 1'b1;
            gap_slots   <= GAP_W'(`LINK_GAP_DEFAULT);
            err_cnt     <= '0;
        end else begin
            if (cfg_write) begin
                case (cfg_addr)
                    reg_ctrl: begin
                        link_enable <= cfg_wdata[CTRL_EN_BIT];
                        a_master_q  <= cfg_wdata[CTRL_A_MASTER_BIT];
                    end
                    // Zero gap would merge frames so it is stored as one
                    reg_gap: gap_slots <= (cfg_wdata[GAP_W-1:0] == '0) ?
                                          GAP_W'(1) : cfg_wdata[GAP_W-1:0];
                    default: ;
                endcase
            end
            // Error count clears on any control write
            if (ctrl_wr) begin
                err_cnt <= '0;
            end else if ((sync_error_a || sync_error_b) && (err_cnt != ERR_MAX)) begin
                err_cnt <= err_cnt + ERR_W'(1);
            end
        end
    end

    // Roles always complementary
    assign role_a = a_master_q ? role_master : role_slave;
    assign role_b = a_master_q ? role_slave  : role_master;

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            reg_ctrl: begin
                cfg_rdata[CTRL_EN_BIT]       = link_enable;
                cfg_rdata[CTRL_A_MASTER_BIT] = a_master_q;
            end
            reg_gap:    cfg_rdata = {{(CFG_DATA_WIDTH-GAP_W){1'b0}}, gap_slots};
            reg_status: cfg_rdata = {{(CFG_DATA_WIDTH-ERR_W){1'b0}}, err_cnt};
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/bit_tick_gen.sv */
`default_nettype none

`include "link_cfg.svh"

module bit_tick_gen (
    input  wire  clk_8mhz,
    input  wire  reset,
    input  wire  pll_locked,
    output logic slot_tick
);

    localparam int TICK_DIV = `LINK_TICK_DIV;
    localparam int CNT_W    = $clog2(TICK_DIV);

    // Divide counter, position inside the current slot
    logic [CNT_W-1:0] div_cnt;

    //////////////////////////////////////////////////
    // Divider
    //////////////////////////////////////////////////

    always_ff @(posedge clk_8mhz) begin
        if (reset || !pll_locked) begin
            // Held at zero until the clock settles
            div_cnt   <= '0;
            slot_tick <= 1'b0;
        end else if (div_cnt == CNT_W'(TICK_DIV - 1)) begin
            // Last cycle of the slot, wrap and fire
            div_cnt   <= '0;
            slot_tick <= 1'b1;
        end else begin
            div_cnt   <= div_cnt + CNT_W'(1);
            slot_tick <= 1'b0;
        end
    end

    // Tick is a single-cycle enable, never a level
    assert property (@(posedge clk_8mhz) disable iff (reset)
        slot_tick |=> !slot_tick)
        else $error("slot_tick high in two consecutive cycles");

endmodule

`default_nettype wire

/* rtl/link_regs_pkg.sv */
`default_nettype none

package link_regs_pkg;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    // Control, gap length, read-only status
    typedef enum logic [1:0] {
        reg_ctrl   = 2'd0,
        reg_gap    = 2'd1,
        reg_status = 2'd2
    } reg_addr_t;

    // Control register bit positions
    localparam int unsigned CTRL_EN_BIT       = 0;
    localparam int unsigned CTRL_A_MASTER_BIT = 1;

    // Data bus width of the register port
    localparam int unsigned CFG_DATA_WIDTH = 8;

endpackage

`default_nettype wire

/* rtl/link_types_pkg.sv */
`default_nettype none

package link_types_pkg;

    //////////////////////////////////////////////////
    // Frame slot positions
    //////////////////////////////////////////////////

    // Slave only, waiting for a low slot after a high one
    // Master drives low in sync, then its bit in data_m
    // Line released in turn, slave drives data_s
    // Gap repeats for the configured number of slots
    typedef enum logic [2:0] {
        slot_hunt   = 3'd0,
        slot_sync   = 3'd1,
        slot_data_m = 3'd2,
        slot_turn   = 3'd3,
        slot_data_s = 3'd4,
        slot_gap    = 3'd5
    } slot_state_t;

    //////////////////////////////////////////////////
    // Partner role on the shared line
    //////////////////////////////////////////////////

    typedef enum logic {
        role_master = 1'b0,
        role_slave  = 1'b1
    } role_t;

endpackage

`default_nettype wire

/* rtl/link_cfg.svh */
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

//////////////////////////////////////////////////
// Slot timing
//////////////////////////////////////////////////

// clk_8mhz cycles per bit slot, gives a 2 MHz slot rate
`define LINK_TICK_DIV 4

//////////////////////////////////////////////////
// Register block sizes and defaults
//////////////////////////////////////////////////

// Idle slots between frames after reset
`define LINK_GAP_DEFAULT 1

// Gap count width, 1 to 15 slots
`define LINK_GAP_WIDTH 4

// Saturating sync error counter width
`define LINK_ERR_WIDTH 4

`endif
